// ==== design/isa_pkg.sv ====
package isa_pkg;

	// Architectural sizes
	localparam int DATA_W = 32;
	localparam int REG_COUNT = 16;
	localparam int REG_W = $clog2(REG_COUNT);
	localparam int MEM_WORDS = 16;
	// Word index bits of the data memory
	localparam int MEM_AW = $clog2(MEM_WORDS);
	localparam int IMM_W = 16;

	typedef logic [REG_W-1:0] reg_idx_t;
	typedef logic [DATA_W-1:0] word_t;
	typedef logic [IMM_W-1:0] imm_t;

	typedef enum logic [2:0] {ADD, SUB, AND, OR, XOR, ADDI, LW, SW} opcode_e;

	// One decoded instruction as the driver presents it
	typedef struct packed {
		opcode_e op;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		logic uses_rs;
		logic uses_rt;
		logic uses_rd;
		imm_t imm;
	} instr_t;

	// Immediate widened to a data word
	function automatic word_t sext_imm(imm_t imm);
		return {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm};
	endfunction

endpackage

// ==== design/pipe_pkg.sv ====
package pipe_pkg;

	import isa_pkg::*;

	// Cycles a load occupies the MEM stage
	localparam int LOAD_CYCLES = 3;
	localparam int LOAD_CNT_W = $clog2(LOAD_CYCLES);

	// EX pipeline register
	typedef struct packed {
		logic valid;
		opcode_e op;
		reg_idx_t rd;
		logic uses_rd;
		logic is_load;
		logic is_store;
		word_t a;
		word_t b;
		// Already sign extended
		word_t imm;
	} ex_ctl_t;

	// MEM pipeline register
	typedef struct packed {
		logic valid;
		reg_idx_t rd;
		logic uses_rd;
		logic is_load;
		logic is_store;
		// ALU result, or the address for loads and stores
		word_t result;
		word_t store_data;
	} mem_ctl_t;

	// Write-back record
	typedef struct packed {
		logic valid;
		reg_idx_t rd;
		word_t data;
	} wb_t;

	typedef enum logic [1:0] {RUN, HAZARD, LOAD_WAIT} issue_state_e;

endpackage

// ==== design/reg_file.sv ====
`timescale 1ns/100ps

module reg_file
	import isa_pkg::*, pipe_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input reg_idx_t rs_addr,
	input reg_idx_t rt_addr,
	output word_t rs_data,
	output word_t rt_data,
	input wb_t wb
);

	word_t regs [REG_COUNT];

	// Asynchronous read ports
	assign rs_data = regs[rs_addr];
	assign rt_data = regs[rt_addr];

	// r0 is never written, so it keeps its reset value of zero
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < REG_COUNT; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wb.valid && wb.rd != '0)
		begin
			regs[wb.rd] <= wb.data;
		end
	end

	// Write-back aimed at r0 leaves it zero
	a_r0_kept: assert property (@(posedge clk) disable iff (!arst_n)
		(wb.valid && wb.rd == '0) |=> regs[0] == '0)
		else $error("r0 changed by a write-back");

endmodule

// ==== design/forward_unit.sv ====
`timescale 1ns/100ps

module forward_unit
	import isa_pkg::*, pipe_pkg::*;
(
	input instr_t instr,
	input word_t rs_data,
	input word_t rt_data,
	input ex_ctl_t ex_ctl,
	input word_t ex_result,
	input mem_ctl_t mem_ctl,
	input logic mem_done,
	input wb_t wb,
	output word_t op_a,
	output word_t op_b,
	output logic load_hazard
);

	logic ex_fwd;
	logic mem_fwd;
	logic wb_fwd;
	logic ex_load;
	logic mem_load_wait;

	// Source qualifiers, r0 never forwards
	always_comb
	begin
		// EX has a value only for ALU ops
		ex_fwd = ex_ctl.valid && ex_ctl.uses_rd && !ex_ctl.is_load && ex_ctl.rd != '0;
		// MEM load counts once its data is back
		mem_fwd = mem_ctl.valid && mem_ctl.uses_rd && !mem_ctl.is_store
			&& (!mem_ctl.is_load || mem_done) && mem_ctl.rd != '0;
		wb_fwd = wb.valid && wb.rd != '0;
		// Loads whose data the issuing op cannot get yet
		ex_load = ex_ctl.valid && ex_ctl.uses_rd && ex_ctl.is_load && ex_ctl.rd != '0;
		mem_load_wait = mem_ctl.valid && mem_ctl.uses_rd && mem_ctl.is_load
			&& !mem_done && mem_ctl.rd != '0;
	end

	// Youngest producer wins
	function automatic word_t pick(reg_idx_t r, word_t rf_val);
		if (ex_fwd && ex_ctl.rd == r)
			return ex_result;
		else if (mem_fwd && mem_ctl.rd == r)
			return mem_ctl.result;
		else if (wb_fwd && wb.rd == r)
			return wb.data;
		return rf_val;
	endfunction

	function automatic logic reads(reg_idx_t r);
		return (instr.uses_rs && instr.rs == r) || (instr.uses_rt && instr.rt == r);
	endfunction

	always_comb
	begin
		op_a = pick(instr.rs, rs_data);
		// rt even for immediate forms, EX picks the immediate itself
		op_b = pick(instr.rt, rt_data);
		// Load-use, data not reachable by any bypass this cycle
		load_hazard = (ex_load && reads(ex_ctl.rd)) || (mem_load_wait && reads(mem_ctl.rd));
	end

endmodule

// ==== design/issue_ctrl.sv ====
`timescale 1ns/100ps

module issue_ctrl
	import pipe_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic instr_valid,
	input logic load_hazard,
	input logic mem_busy,
	output logic stall,
	output logic freeze,
	output logic bubble
);

	issue_state_e state;
	issue_state_e state_next;
	logic hazard;

	// Hazard matters only with an instruction waiting
	assign hazard = instr_valid && load_hazard;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			state <= RUN;
		else
			state <= state_next;
	end

	// Outputs react in the cycle the condition shows up
	// mem_busy wins over a load-use hazard in every state
	always_comb
	begin
		state_next = state;
		stall = 1'b0;
		freeze = 1'b0;
		bubble = 1'b0;
		case (state)
			RUN, HAZARD:
			begin
				if (mem_busy)
				begin
					freeze = 1'b1;
					stall = 1'b1;
					state_next = LOAD_WAIT;
				end
				else if (hazard)
				begin
					stall = 1'b1;
					bubble = 1'b1;
					state_next = HAZARD;
				end
				else
					state_next = RUN;
			end
			LOAD_WAIT:
			begin
				if (mem_busy)
				begin
					freeze = 1'b1;
					stall = 1'b1;
				end
				// Load finished, a waiting user may still need a bubble
				else if (hazard)
				begin
					stall = 1'b1;
					bubble = 1'b1;
					state_next = HAZARD;
				end
				else
					state_next = RUN;
			end
			default: state_next = RUN;
		endcase
	end

	a_freeze_stalls: assert property (@(posedge clk) disable iff (!arst_n)
		freeze |-> stall)
		else $error("freeze without stall");

endmodule

// ==== design/load_timer.sv ====
`timescale 1ns/100ps

module load_timer
	import pipe_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic start,
	output logic done
);

	logic [LOAD_CNT_W-1:0] count;

	// Zero means idle
	// start loads the remaining cycles, then count down to one
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			count <= '0;
		else if (start)
			count <= LOAD_CNT_W'(LOAD_CYCLES - 1);
		else if (count != '0)
			count <= count - 1'b1;
	end

	// Last MEM cycle of the load
	assign done = (count == LOAD_CNT_W'(1));

	// MEM must not hand over a new load before the old one completes
	a_no_restart: assert property (@(posedge clk) disable iff (!arst_n)
		start |-> count == '0)
		else $error("load_timer restarted while counting");

endmodule

// ==== design/exec_stage.sv ====
`timescale 1ns/100ps

module exec_stage
	import isa_pkg::*, pipe_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input instr_t instr,
	input logic accept,
	input word_t op_a,
	input word_t op_b,
	input logic freeze,
	input logic bubble,
	output ex_ctl_t ex_ctl,
	output word_t ex_result,
	output mem_ctl_t mem_in
);

	ex_ctl_t ex_q;
	ex_ctl_t ex_next;
	word_t alu;

	// Issuing instruction with its forwarded operands
	always_comb
	begin
		ex_next.valid = 1'b1;
		ex_next.op = instr.op;
		ex_next.rd = instr.rd;
		ex_next.uses_rd = instr.uses_rd;
		ex_next.is_load = (instr.op == LW);
		ex_next.is_store = (instr.op == SW);
		ex_next.a = op_a;
		ex_next.b = op_b;
		ex_next.imm = sext_imm(instr.imm);
	end

	// Hold under freeze, else take the new op or an empty slot
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			ex_q <= '0;
		else if (!freeze)
			ex_q <= (accept && !bubble) ? ex_next : '0;
	end

	always_comb
	begin
		case (ex_q.op)
			ADD: alu = ex_q.a + ex_q.b;
			SUB: alu = ex_q.a - ex_q.b;
			AND: alu = ex_q.a & ex_q.b;
			OR: alu = ex_q.a | ex_q.b;
			XOR: alu = ex_q.a ^ ex_q.b;
			// ADDI and the memory address
			default: alu = ex_q.a + ex_q.imm;
		endcase
	end

	assign ex_ctl = ex_q;
	assign ex_result = alu;

	// Next MEM entry, store data rides along from rt
	assign mem_in = '{valid: ex_q.valid, rd: ex_q.rd, uses_rd: ex_q.uses_rd,
		is_load: ex_q.is_load, is_store: ex_q.is_store, result: alu, store_data: ex_q.b};

endmodule

// ==== design/mem_stage.sv ====
`timescale 1ns/100ps

module mem_stage
	import isa_pkg::*, pipe_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input mem_ctl_t mem_in,
	input logic freeze,
	output mem_ctl_t mem_ctl,
	output logic mem_done,
	output logic mem_busy,
	output wb_t wb
);

	mem_ctl_t mem_q;
	// Set in the first cycle of a new MEM entry
	logic fresh;
	logic timer_start;
	logic [MEM_AW-1:0] addr;
	word_t rdata;
	word_t dmem [MEM_WORDS];
	wb_t wb_q;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			mem_q <= '0;
			fresh <= 1'b0;
		end
		else if (freeze)
			fresh <= 1'b0;
		else
		begin
			mem_q <= mem_in;
			fresh <= 1'b1;
		end
	end

	// Word index from the low address bits
	assign addr = mem_q.result[MEM_AW-1:0];
	assign rdata = dmem[addr];

	always_ff @(posedge clk)
	begin
		if (mem_q.valid && mem_q.is_store)
			dmem[addr] <= mem_q.store_data;
	end

	// Timer runs once per load
	assign timer_start = fresh && mem_q.valid && mem_q.is_load;

	load_timer u_load_timer (
		.clk(clk),
		.arst_n(arst_n),
		.start(timer_start),
		.done(mem_done)
	);

	assign mem_busy = mem_q.valid && mem_q.is_load && !mem_done;

	// Loads present their memory data as the result
	always_comb
	begin
		mem_ctl = mem_q;
		if (mem_q.is_load)
			mem_ctl.result = rdata;
	end

	// Empty WB slot while MEM is held
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			wb_q <= '0;
		else if (freeze)
			wb_q <= '0;
		else
			wb_q <= '{valid: mem_q.valid && mem_q.uses_rd && !mem_q.is_store,
				rd: mem_q.rd, data: mem_ctl.result};
	end

	assign wb = wb_q;

endmodule

// ==== design/backend_top.sv ====
`timescale 1ns/100ps

module backend_top
	import isa_pkg::*, pipe_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic instr_valid,
	input instr_t instr,
	output logic stall,
	output wb_t wb_out
);

	word_t rs_data;
	word_t rt_data;
	word_t op_a;
	word_t op_b;
	word_t ex_result;
	ex_ctl_t ex_ctl;
	mem_ctl_t mem_in;
	mem_ctl_t mem_ctl;
	logic mem_done;
	logic mem_busy;
	logic load_hazard;
	logic freeze;
	logic bubble;

	// wb_out also feeds the write port and the WB bypass
	reg_file u_reg_file (
		.clk(clk), .arst_n(arst_n),
		.rs_addr(instr.rs), .rt_addr(instr.rt),
		.rs_data(rs_data), .rt_data(rt_data),
		.wb(wb_out)
	);

	forward_unit u_forward_unit (
		.instr(instr), .rs_data(rs_data), .rt_data(rt_data),
		.ex_ctl(ex_ctl), .ex_result(ex_result),
		.mem_ctl(mem_ctl), .mem_done(mem_done), .wb(wb_out),
		.op_a(op_a), .op_b(op_b), .load_hazard(load_hazard)
	);

	issue_ctrl u_issue_ctrl (
		.clk(clk), .arst_n(arst_n),
		.instr_valid(instr_valid), .load_hazard(load_hazard), .mem_busy(mem_busy),
		.stall(stall), .freeze(freeze), .bubble(bubble)
	);

	exec_stage u_exec_stage (
		.clk(clk), .arst_n(arst_n),
		.instr(instr), .accept(instr_valid && !stall),
		.op_a(op_a), .op_b(op_b), .freeze(freeze), .bubble(bubble),
		.ex_ctl(ex_ctl), .ex_result(ex_result), .mem_in(mem_in)
	);

	mem_stage u_mem_stage (
		.clk(clk), .arst_n(arst_n),
		.mem_in(mem_in), .freeze(freeze),
		.mem_ctl(mem_ctl), .mem_done(mem_done), .mem_busy(mem_busy),
		.wb(wb_out)
	);

endmodule

// ==== include/ref_model.svh ====
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// Sequential model of registers and data memory, one instruction at a time in issue order
word_t model_regs [REG_COUNT] = '{default: '0};
word_t model_mem [MEM_WORDS] = '{default: '0};
// Write-backs still to be seen on wb_out
wb_t expected [$];

// Run one accepted instruction and queue its write-back
function automatic void predict(instr_t in);
	word_t a;
	word_t b;
	word_t imm;
	word_t result;
	logic [MEM_AW-1:0] addr;
	wb_t entry;
	a = model_regs[in.rs];
	b = model_regs[in.rt];
	// Sign bit of the 16-bit immediate copied upward
	imm = {{(DATA_W-IMM_W){in.imm[IMM_W-1]}}, in.imm};
	case (in.op)
		ADD: result = a + b;
		SUB: result = a - b;
		AND: result = a & b;
		OR: result = a | b;
		XOR: result = a ^ b;
		default: result = a + imm;
	endcase
	addr = result[MEM_AW-1:0];
	if (in.op == SW)
		model_mem[addr] = b;
	else if (in.uses_rd)
	begin
		if (in.op == LW)
			result = model_mem[addr];
		// r0 stays zero
		if (in.rd != '0)
			model_regs[in.rd] = result;
		entry = '{valid: 1'b1, rd: in.rd, data: result};
		expected.push_back(entry);
	end
endfunction

// Oldest expected write-back, 0 when nothing is queued
function automatic bit pop_expected(output wb_t entry);
	entry = '0;
	if (expected.size() == 0)
		return 1'b0;
	entry = expected.pop_front();
	return 1'b1;
endfunction

`endif

// ==== test/backend_tb.sv ====
`timescale 1ns/100ps

module backend_tb
	import isa_pkg::*, pipe_pkg::*;
();

	// Instruction count of each test
	localparam int N_ALU = 20;
	localparam int N_FWD = 10;
	localparam int N_LOAD_USE = 11;
	localparam int N_STORE_LOAD = 10;
	localparam int N_ZERO = 8;
	localparam int INSTR_TOTAL = N_ALU + N_FWD + N_LOAD_USE + N_STORE_LOAD + N_ZERO;
	localparam int TIMEOUT_CYCLES = INSTR_TOTAL * (3 + LOAD_CYCLES) + 50;

	logic clk;
	logic arst_n;
	logic instr_valid;
	instr_t instr;
	logic stall;
	wb_t wb_out;

	`include "ref_model.svh"

	logic [31:0] rng = 32'd2974;
	// Assertion failures and procedural failures kept apart
	int check_errors = 0;
	int flow_errors = 0;
	int errors_at_start = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycles = 0;
	int stalls_seen = 0;
	logic idle_check = 1'b0;
	// Write-back seen mid-cycle and the entry it is held against
	wb_t seen_wb = '0;
	wb_t exp_wb = '0;
	logic have_exp = 1'b0;

	backend_top DUT (
		.clk(clk),
		.arst_n(arst_n),
		.instr_valid(instr_valid),
		.instr(instr),
		.stall(stall),
		.wb_out(wb_out)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// xorshift32
	function automatic logic [31:0] rand_word();
		rng ^= rng << 13;
		rng ^= rng >> 17;
		rng ^= rng << 5;
		return rng;
	endfunction

	function automatic instr_t alu_rr(opcode_e op, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
		instr_t i;
		i = '0;
		i.op = op;
		i.rd = rd;
		i.rs = rs;
		i.rt = rt;
		i.uses_rs = 1'b1;
		i.uses_rt = 1'b1;
		i.uses_rd = 1'b1;
		return i;
	endfunction

	// ADDI and LW, rs plus immediate
	function automatic instr_t alu_imm(opcode_e op, reg_idx_t rd, reg_idx_t rs, imm_t imm);
		instr_t i;
		i = '0;
		i.op = op;
		i.rd = rd;
		i.rs = rs;
		i.uses_rs = 1'b1;
		i.uses_rd = 1'b1;
		i.imm = imm;
		return i;
	endfunction

	function automatic instr_t store_word(reg_idx_t rt, reg_idx_t rs, imm_t imm);
		instr_t i;
		i = '0;
		i.op = SW;
		i.rs = rs;
		i.rt = rt;
		i.uses_rs = 1'b1;
		i.uses_rt = 1'b1;
		i.imm = imm;
		return i;
	endfunction

	// Present one instruction, hold it through stall
	// Model runs it just before the accepting edge
	task automatic issue(input instr_t i);
		@(posedge clk);
		instr <= i;
		instr_valid <= 1'b1;
		@(negedge clk);
		while (stall)
		begin
			stalls_seen++;
			@(negedge clk);
		end
		predict(i);
	endtask

	// Idle until every expected write-back has shown up
	task automatic drain();
		@(posedge clk);
		instr_valid <= 1'b0;
		@(negedge clk);
		while (expected.size() != 0)
			@(negedge clk);
		repeat (2) @(negedge clk);
	endtask

	task automatic report_test(input string name);
		int now;
		now = check_errors + flow_errors;
		tests_run++;
		if (now == errors_at_start)
			$display("Test %s passed", name);
		else
		begin
			tests_failed++;
			$display("Test %s failed with %0d failing checks", name, now - errors_at_start);
		end
		errors_at_start = now;
	endtask

	task automatic independent_alu();
		reg_idx_t rs;
		reg_idx_t rt;
		opcode_e op;
		// r1 to r7 get random values
		for (int r = 1; r < 8; r++)
			issue(alu_imm(ADDI, reg_idx_t'(r), 4'd0, imm_t'(rand_word())));
		// Results land in r8 to r15, sources only in r1 to r7
		for (int n = 7; n < N_ALU; n++)
		begin
			op = opcode_e'(3'(rand_word() % 5));
			rs = reg_idx_t'(1 + rand_word() % 7);
			rt = reg_idx_t'(1 + rand_word() % 7);
			issue(alu_rr(op, reg_idx_t'(8 + n % 8), rs, rt));
		end
		drain();
		report_test("independent_alu");
	endtask

	task automatic forward_chain();
		issue(alu_imm(ADDI, 4'd1, 4'd0, imm_t'(rand_word())));
		// Each op needs the one right before it, from EX
		issue(alu_rr(ADD, 4'd2, 4'd1, 4'd1));
		// Second operand from MEM, then from WB
		issue(alu_rr(SUB, 4'd3, 4'd2, 4'd1));
		issue(alu_rr(XOR, 4'd4, 4'd3, 4'd1));
		issue(alu_rr(OR, 4'd5, 4'd4, 4'd2));
		issue(alu_rr(AND, 4'd6, 4'd5, 4'd3));
		// r1 rewritten twice in a row, youngest value wins
		issue(alu_rr(ADD, 4'd1, 4'd1, 4'd6));
		issue(alu_imm(ADDI, 4'd1, 4'd1, imm_t'(rand_word())));
		issue(alu_rr(ADD, 4'd7, 4'd1, 4'd1));
		issue(alu_rr(SUB, 4'd7, 4'd7, 4'd1));
		drain();
		report_test("forward_chain");
	endtask

	task automatic load_use();
		issue(alu_imm(ADDI, 4'd1, 4'd0, imm_t'(rand_word())));
		issue(store_word(4'd1, 4'd0, 16'd4));
		issue(alu_imm(LW, 4'd2, 4'd0, 16'd4));
		stalls_seen = 0;
		// Direct user of the loaded value
		issue(alu_rr(ADD, 4'd3, 4'd2, 4'd2));
		assert (stalls_seen > 0)
		else
		begin
			$display("Load followed directly by its user never raised stall");
			flow_errors++;
		end
		// User one slot behind, load still waiting in MEM
		issue(alu_imm(LW, 4'd4, 4'd0, 16'd4));
		issue(alu_imm(ADDI, 4'd5, 4'd0, 16'd1));
		issue(alu_rr(ADD, 4'd6, 4'd4, 4'd5));
		// Loaded value as store data
		issue(alu_imm(LW, 4'd7, 4'd0, 16'd4));
		issue(store_word(4'd7, 4'd0, 16'd8));
		issue(alu_imm(LW, 4'd8, 4'd0, 16'd8));
		issue(alu_rr(XOR, 4'd9, 4'd8, 4'd1));
		drain();
		report_test("load_use");
	endtask

	task automatic store_load();
		issue(alu_imm(ADDI, 4'd1, 4'd0, imm_t'(rand_word())));
		issue(alu_imm(ADDI, 4'd2, 4'd0, imm_t'(rand_word())));
		issue(store_word(4'd1, 4'd0, 16'd3));
		issue(alu_imm(LW, 4'd3, 4'd0, 16'd3));
		// Overwrite the same word, then read it back
		issue(store_word(4'd2, 4'd0, 16'd3));
		issue(alu_imm(LW, 4'd4, 4'd0, 16'd3));
		// Address from a register plus offset, word 12
		issue(alu_imm(ADDI, 4'd5, 4'd0, 16'd10));
		issue(store_word(4'd2, 4'd5, 16'd2));
		issue(alu_imm(LW, 4'd6, 4'd0, 16'd12));
		issue(alu_rr(ADD, 4'd7, 4'd6, 4'd3));
		drain();
		report_test("store_load");
	endtask

	task automatic zero_reg();
		issue(alu_imm(ADDI, 4'd1, 4'd0, imm_t'(rand_word())));
		// Writes aimed at r0
		issue(alu_imm(ADDI, 4'd0, 4'd0, imm_t'(rand_word())));
		issue(alu_rr(ADD, 4'd0, 4'd1, 4'd1));
		// r0 in EX with a nonzero result must not forward
		issue(alu_rr(ADD, 4'd2, 4'd0, 4'd1));
		issue(store_word(4'd1, 4'd0, 16'd5));
		issue(alu_imm(LW, 4'd0, 4'd0, 16'd5));
		issue(alu_rr(ADD, 4'd3, 4'd0, 4'd0));
		issue(alu_rr(OR, 4'd4, 4'd0, 4'd1));
		drain();
		report_test("zero_reg");
	endtask

	// Capture wb_out and its expected entry away from the clock edge
	always @(negedge clk)
	begin
		seen_wb = wb_out;
		if (wb_out.valid)
			have_exp = pop_expected(exp_wb);
		else
			have_exp = 1'b0;
	end

	reset_quiet: assert property (@(posedge clk)
		(!arst_n || idle_check) |-> (!stall && !wb_out.valid))
		else
		begin
			$display("stall or wb_out.valid high during reset or in the first idle cycle");
			check_errors++;
		end

	wb_expected: assert property (@(posedge clk) disable iff (!arst_n)
		seen_wb.valid |-> have_exp)
		else
		begin
			$display("Write-back to r%0d arrived with no instruction waiting for it",
				seen_wb.rd);
			check_errors++;
		end

	wb_rd_match: assert property (@(posedge clk) disable iff (!arst_n)
		(seen_wb.valid && have_exp) |-> seen_wb.rd == exp_wb.rd)
		else
		begin
			$display("Mismatch wb_out.rd: got 0x%h, expected 0x%h", seen_wb.rd, exp_wb.rd);
			check_errors++;
		end

	wb_data_match: assert property (@(posedge clk) disable iff (!arst_n)
		(seen_wb.valid && have_exp) |-> seen_wb.data == exp_wb.data)
		else
		begin
			$display("Mismatch wb_out.data: got 0x%h, expected 0x%h",
				seen_wb.data, exp_wb.data);
			check_errors++;
		end

	// Run limit sized from the instruction count
	initial
	begin
		while (cycles < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, %0d write-backs never arrived",
			cycles, expected.size());
		$display("Errors found");
		$finish;
	end

	initial
	begin
		arst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		// One posedge of idle right after release
		@(negedge clk);
		idle_check = 1'b1;
		@(negedge clk);
		idle_check = 1'b0;
		report_test("reset");
		independent_alu();
		forward_chain();
		load_use();
		store_load();
		zero_reg();
		$display("Tests run %0d, failed %0d, failing checks %0d",
			tests_run, tests_failed, check_errors + flow_errors);
		if (check_errors + flow_errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+include
design/isa_pkg.sv
design/pipe_pkg.sv
design/reg_file.sv
design/forward_unit.sv
design/issue_ctrl.sv
design/load_timer.sv
design/exec_stage.sv
design/mem_stage.sv
design/backend_top.sv
test/backend_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the backend testbench with Verilator, run it, judge the result from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f build.f --top-module backend_tb --Mdir "$OBJ" -o backend_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/backend_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "No errors" "$LOG"; then
	exit 0
fi
echo "Simulation did not report a clean run, see $LOG"
exit 1
